/* project.f */
common/map_bus_pkg.sv
common/map_cfg_pkg.sv
mapper/bank_ctrl.sv
mapper/prg_map.sv
mapper/chr_map.sv
src/map_top.sv
verification/map_sva.sv
verification/map_tb.sv

/* run.sh */
#!/bin/sh
# build and run the mapper testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module map_tb -f project.f -o map_sim || exit 1
./obj_dir/map_sim > sim.log 2>&1 || echo "simulator returned an error status" >> sim.log
cat sim.log
grep -q "Test failed" sim.log && exit 1 || grep -q "Test passed" sim.log || exit 1
exit 0

/* verification/map_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module map_tb
	import map_bus_pkg::*;
	import map_cfg_pkg::*;
();

	localparam int PRG_BANK_BITS = 4;
	localparam int CHR_BANK_BITS = 4;
	localparam int APB_TIMEOUT = 8;	// cycles before giving up on pready

	typedef enum logic [2:0]
	{
		OP_CPU_WR,
		OP_CPU_RD,
		OP_PPU_RD,
		OP_PPU_WR,
		OP_APB_WR,
		OP_APB_RD
	} op_e;

	typedef struct packed
	{
		op_e op;
		logic [15:0] addr;	// cpu, ppu or apb address
		logic [7:0] data;
		map_id_e map_idx;
		logic mir_v;
		logic chr_ram;
	} step_t;

	logic m2 = 1'b0;
	logic arst_n;
	cpu_bus_t cpu_in;
	ppu_bus_t ppu_in;
	map_cfg_t cfg_in;
	logic [7:0] prg_do;
	logic [7:0] chr_do;
	logic psel;
	logic penable;
	logic pwrite;
	logic [7:0] paddr;
	logic [7:0] pwdata;
	mem_ctrl_t prg;
	mem_ctrl_t chr;
	cpu_ret_t cpu_ret;
	ppu_ret_t ppu_ret;
	logic ciram_a10;
	logic ciram_ce;
	logic [7:0] prdata;
	logic pready;
	logic pslverr;

	step_t steps[$];
	logic [7:0] bank_m;	// reference copy of the bank register
	logic [31:0] lcg_state;
	int value_errors;
	int other_errors;

	always #5 m2 = ~m2;

	map_top #(
		.PRG_BANK_BITS(PRG_BANK_BITS),
		.CHR_BANK_BITS(CHR_BANK_BITS)
	) DUT (
		.m2(m2),
		.arst_n(arst_n),
		.cpu(cpu_in),
		.ppu(ppu_in),
		.cfg(cfg_in),
		.prg_do(prg_do),
		.chr_do(chr_do),
		.psel(psel),
		.penable(penable),
		.pwrite(pwrite),
		.paddr(paddr),
		.pwdata(pwdata),
		.prg(prg),
		.chr(chr),
		.cpu_ret(cpu_ret),
		.ppu_ret(ppu_ret),
		.ciram_a10(ciram_a10),
		.ciram_ce(ciram_ce),
		.prdata(prdata),
		.pready(pready),
		.pslverr(pslverr)
	);

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1103515245 + 32'd12345;
	endfunction

	function automatic logic [7:0] rand_byte();
		lcg_state = lcg_next(lcg_state);
		return lcg_state[23:16];	// upper bits cycle better
	endfunction

	task automatic add_step(input op_e op, input logic [15:0] addr, input logic [7:0] data,
		input map_id_e map_idx, input logic mir_v, input logic chr_ram);
		steps.push_back('{op, addr, data, map_idx, mir_v, chr_ram});
	endtask

	task automatic build_table();
		logic [15:0] a;
		logic [7:0] d;
		int i;
		add_step(OP_CPU_RD, 16'h8000, 8'h00, MAP_070, 1'b1, 1'b0);	// bank 0 after reset
		add_step(OP_CPU_RD, 16'hc000, 8'h00, MAP_070, 1'b1, 1'b0);
		for (i = 0; i < 6; i++)
		begin
			a = {rand_byte(), rand_byte()} | 16'h8000;
			d = rand_byte();
			add_step(OP_CPU_WR, a, d, MAP_070, 1'b1, 1'b0);
			add_step(OP_CPU_RD, {2'b10, a[13:0]}, 8'h00, MAP_070, 1'b1, 1'b0);
			add_step(OP_PPU_RD, {3'b000, a[12:0]}, 8'h00, MAP_070, 1'b0, 1'b0);
		end
		a = {rand_byte(), rand_byte()} & 16'h7fff;	// below the mapper window
		add_step(OP_CPU_WR, a, ~d, MAP_070, 1'b1, 1'b0);
		add_step(OP_CPU_RD, 16'h9234, 8'h00, MAP_070, 1'b1, 1'b0);
		add_step(OP_CPU_RD, 16'hffff, 8'h00, MAP_070, 1'b1, 1'b0);
		add_step(OP_CPU_RD, 16'h1234, 8'h00, MAP_070, 1'b1, 1'b0);
		add_step(OP_PPU_WR, 16'h0abc, rand_byte(), MAP_070, 1'b1, 1'b1);
		add_step(OP_PPU_WR, 16'h1abc, rand_byte(), MAP_070, 1'b1, 1'b0);
		for (i = 0; i < 8; i++)
		begin
			a = 16'h2000 + 16'(i % 4) * 16'h0400;	// each of the four nametables
			add_step(OP_PPU_RD, a, 8'h00, MAP_070, i < 4, 1'b0);
		end
		add_step(OP_CPU_WR, 16'h8000, 8'h80, MAP_152, 1'b0, 1'b0);
		add_step(OP_PPU_RD, 16'h2000, 8'h00, MAP_152, 1'b0, 1'b0);
		add_step(OP_PPU_RD, 16'h2c00, 8'h00, MAP_152, 1'b1, 1'b0);
		add_step(OP_CPU_WR, 16'hbfff, 8'h75, MAP_152, 1'b0, 1'b0);
		add_step(OP_PPU_RD, 16'h2400, 8'h00, MAP_152, 1'b1, 1'b0);
		add_step(OP_APB_RD, 16'h0000, 8'h00, MAP_070, 1'b1, 1'b0);
		add_step(OP_APB_WR, 16'h0000, 8'ha5, MAP_070, 1'b1, 1'b0);
		add_step(OP_APB_RD, 16'h0000, 8'h00, MAP_070, 1'b1, 1'b0);
		add_step(OP_APB_RD, 16'h007f, 8'h00, MAP_070, 1'b1, 1'b0);
		add_step(OP_APB_RD, 16'h007f, 8'h00, MAP_152, 1'b1, 1'b0);
		add_step(OP_APB_RD, 16'h0055, 8'h00, MAP_070, 1'b1, 1'b0);
		add_step(OP_APB_WR, 16'h0012, 8'h3c, MAP_070, 1'b1, 1'b0);	// no such register
		add_step(OP_APB_RD, 16'h0000, 8'h00, MAP_070, 1'b1, 1'b0);
		add_step(OP_CPU_RD, 16'h8000, 8'h00, MAP_070, 1'b1, 1'b0);
	endtask

	task automatic set_idle();
		cpu_in = '{16'h0000, 8'h00, 1'b1};
		ppu_in = '{14'h0155, 8'h00, 1'b1, 1'b1};
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = 8'h00;
		pwdata = 8'h00;
	endtask

	task automatic drive_inputs(input step_t e, input logic access);
		set_idle();
		cfg_in = '{e.map_idx, e.mir_v, e.chr_ram};
		prg_do = rand_byte();
		chr_do = rand_byte();
		case (e.op)
			OP_CPU_WR: cpu_in = '{e.addr, e.data, 1'b0};
			OP_CPU_RD: cpu_in = '{e.addr, rand_byte(), 1'b1};
			OP_PPU_RD: ppu_in = '{e.addr[13:0], 8'h00, 1'b0, 1'b1};
			OP_PPU_WR: ppu_in = '{e.addr[13:0], e.data, 1'b1, 1'b0};
			default:
			begin
				psel = 1'b1;
				penable = access;
				pwrite = (e.op == OP_APB_WR);
				paddr = e.addr[7:0];
				pwdata = e.data;
				if (e.op == OP_APB_WR)
					cpu_in = '{16'hfff0, ~e.data, 1'b0};	// competing cpu store
			end
		endcase
	endtask

	task automatic report_mismatch(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		$display("ERROR %s: got 0x%0h, expected 0x%0h at %0t", name, got, exp, $time);
		value_errors++;
	endtask

	task automatic check_outputs();
		logic [3:0] prg_sel;
		logic [17:0] exp_prg_addr;
		logic [17:0] exp_chr_addr;
		logic exp_chr_we;
		logic exp_a10;
		logic [7:0] exp_prdata;
		prg_sel = cpu_in.addr[14] ? 4'hf : bank_m[7:4];	// last bank is fixed
		exp_prg_addr = {prg_sel, cpu_in.addr[13:0]};
		exp_chr_addr = {1'b0, bank_m[3:0], ppu_in.addr[12:0]};
		exp_chr_we = cfg_in.chr_ram & ~ppu_in.we_n & ~ppu_in.addr[13];
		if (cfg_in.map_idx == MAP_152)
			exp_a10 = bank_m[7];
		else if (cfg_in.mir_v)
			exp_a10 = ppu_in.addr[10];
		else
			exp_a10 = ppu_in.addr[11];
		case (paddr)
			SST_BANK: exp_prdata = bank_m;
			SST_MAP_IDX: exp_prdata = cfg_in.map_idx;
			default: exp_prdata = 8'hff;
		endcase
		if (prg.ce !== cpu_in.addr[15])
			report_mismatch("prg.ce", 32'(prg.ce), 32'(cpu_in.addr[15]));
		if (prg.oe !== cpu_in.rw)
			report_mismatch("prg.oe", 32'(prg.oe), 32'(cpu_in.rw));
		if (prg.we !== 1'b0)
			report_mismatch("prg.we", 32'(prg.we), 32'd0);
		if (prg.addr !== exp_prg_addr)
			report_mismatch("prg.addr", 32'(prg.addr), 32'(exp_prg_addr));
		if (!cpu_in.rw && prg.dati !== cpu_in.data)
			report_mismatch("prg.dati", 32'(prg.dati), 32'(cpu_in.data));
		if (cpu_ret.oe !== (cpu_in.addr[15] & cpu_in.rw))
			report_mismatch("cpu_ret.oe", 32'(cpu_ret.oe), 32'(cpu_in.addr[15] & cpu_in.rw));
		if (cpu_ret.oe && cpu_ret.dout !== prg_do)
			report_mismatch("cpu_ret.dout", 32'(cpu_ret.dout), 32'(prg_do));
		if (chr.ce !== ~ppu_in.addr[13])
			report_mismatch("chr.ce", 32'(chr.ce), 32'(~ppu_in.addr[13]));
		if (chr.oe !== ~ppu_in.oe_n)
			report_mismatch("chr.oe", 32'(chr.oe), 32'(~ppu_in.oe_n));
		if (chr.we !== exp_chr_we)
			report_mismatch("chr.we", 32'(chr.we), 32'(exp_chr_we));
		if (chr.addr !== exp_chr_addr)
			report_mismatch("chr.addr", 32'(chr.addr), 32'(exp_chr_addr));
		if (exp_chr_we && chr.dati !== ppu_in.data)
			report_mismatch("chr.dati", 32'(chr.dati), 32'(ppu_in.data));
		if (ppu_ret.oe !== (~ppu_in.addr[13] & ~ppu_in.oe_n))
			report_mismatch("ppu_ret.oe", 32'(ppu_ret.oe), 32'(~ppu_in.addr[13] & ~ppu_in.oe_n));
		if (ppu_ret.oe && ppu_ret.dout !== chr_do)
			report_mismatch("ppu_ret.dout", 32'(ppu_ret.dout), 32'(chr_do));
		if (ciram_ce !== ppu_in.addr[13])
			report_mismatch("ciram_ce", 32'(ciram_ce), 32'(ppu_in.addr[13]));
		if (ciram_a10 !== exp_a10)
			report_mismatch("ciram_a10", 32'(ciram_a10), 32'(exp_a10));
		if (pready !== (psel & penable))
			report_mismatch("pready", 32'(pready), 32'(psel & penable));
		if (pslverr !== 1'b0)
			report_mismatch("pslverr", 32'(pslverr), 32'd0);
		if (pready && prdata !== exp_prdata)
			report_mismatch("prdata", 32'(prdata), 32'(exp_prdata));
	endtask

	task automatic finish_run();
		$display("errors: %0d value mismatches, %0d other failures", value_errors, other_errors);
		if (value_errors == 0 && other_errors == 0)
			$display("Test passed");
		else
			$display("Test failed");
		$finish;
	endtask

	task automatic run_step(input step_t e);
		int waited;
		@(posedge m2);
		#1;
		drive_inputs(e, 1'b0);
		@(negedge m2);
		check_outputs();	// cpu, ppu or apb setup phase
		if (e.op == OP_APB_WR || e.op == OP_APB_RD)
		begin
			@(posedge m2);
			#1;
			drive_inputs(e, 1'b1);
			waited = 0;
			@(negedge m2);
			while (!pready && waited < APB_TIMEOUT)
			begin
				@(negedge m2);
				waited++;
			end
			if (!pready)
			begin
				$display("APB transfer to address 0x%0h never completed", e.addr[7:0]);
				other_errors++;
				finish_run();
			end
			else
			begin
				if (waited != 0)
				begin
					$display("APB transfer took %0d extra cycles", waited);
					other_errors++;
				end
				check_outputs();
				if (e.op == OP_APB_WR && e.addr[7:0] == 8'h00)
					bank_m = e.data;	// loads at the access edge
			end
		end
		else if (e.op == OP_CPU_WR && e.addr[15])
			bank_m = e.data;
	endtask

	initial
	begin
		int i;
		lcg_state = 32'd48;
		value_errors = 0;
		other_errors = 0;
		bank_m = 8'h00;
		arst_n = 1'b0;
		cfg_in = '{MAP_070, 1'b1, 1'b0};
		prg_do = 8'h00;
		chr_do = 8'h00;
		set_idle();
		build_table();
		repeat (3) @(posedge m2);
		#1;
		arst_n = 1'b1;
		for (i = 0; i < steps.size(); i++)
			run_step(steps[i]);
		finish_run();
	end

endmodule

`default_nettype wire

/* verification/map_sva.sv */
`timescale 1ns/1ps
`default_nettype none

module map_sva
	import map_bus_pkg::*;
#(
	parameter int PRG_BANK_BITS = 4,
	parameter int CHR_BANK_BITS = 4
)
(
	input wire logic m2,
	input wire logic arst_n,
	input wire cpu_bus_t cpu,
	input wire logic psel,
	input wire logic penable,
	input wire logic pready,
	input wire logic pslverr,
	input wire logic [PRG_BANK_BITS-1:0] prg_bank,
	input wire logic [CHR_BANK_BITS-1:0] chr_bank
);

	localparam int PRG_LSB = 4;	// prg field in the written byte

	logic cpu_bank_wr;
	logic [7:0] cpu_data;

	assign cpu_bank_wr = cpu.addr[15] & ~cpu.rw & ~psel;
	assign cpu_data = cpu.data;

	// zero wait states, so ready only in the access phase
	ready_in_access: assert property (@(posedge m2) disable iff (!arst_n)
		pready |-> (psel && penable))
		else $error("pready high outside an APB access phase");

	no_slave_error: assert property (@(posedge m2) disable iff (!arst_n) !pslverr)
		else $error("pslverr asserted");

	cpu_write_loads: assert property (@(posedge m2) disable iff (!arst_n)
		cpu_bank_wr |=> (prg_bank == $past(cpu_data[PRG_LSB +: PRG_BANK_BITS]))
			&& (chr_bank == $past(cpu_data[CHR_BANK_BITS-1:0])))
		else $error("bank register missed a cpu write");

endmodule

bind bank_ctrl map_sva #(
	.PRG_BANK_BITS(PRG_BANK_BITS),
	.CHR_BANK_BITS(CHR_BANK_BITS)
) u_map_sva (
	.m2(m2),
	.arst_n(arst_n),
	.cpu(cpu),
	.psel(psel),
	.penable(penable),
	.pready(pready),
	.pslverr(pslverr),
	.prg_bank(prg_bank),
	.chr_bank(chr_bank)
);

`default_nettype wire

/* src/map_top.sv */
`timescale 1ns/1ps
`default_nettype none

module map_top
	import map_bus_pkg::*;
	import map_cfg_pkg::*;
#(
	parameter int PRG_BANK_BITS = 4,
	parameter int CHR_BANK_BITS = 4
)
(
	input wire logic m2,
	input wire logic arst_n,
	input wire cpu_bus_t cpu,
	input wire ppu_bus_t ppu,
	input wire map_cfg_t cfg,
	input wire logic [7:0] prg_do,
	input wire logic [7:0] chr_do,
	input wire logic psel,
	input wire logic penable,
	input wire logic pwrite,
	input wire logic [7:0] paddr,
	input wire logic [7:0] pwdata,
	output mem_ctrl_t prg,
	output mem_ctrl_t chr,
	output cpu_ret_t cpu_ret,
	output ppu_ret_t ppu_ret,
	output logic ciram_a10,
	output logic ciram_ce,
	output logic [7:0] prdata,
	output logic pready,
	output logic pslverr
);

	logic [PRG_BANK_BITS-1:0] prg_bank;
	logic [CHR_BANK_BITS-1:0] chr_bank;

	bank_ctrl #(
		.PRG_BANK_BITS(PRG_BANK_BITS),
		.CHR_BANK_BITS(CHR_BANK_BITS)
	) u_bank_ctrl (
		.m2(m2),
		.arst_n(arst_n),
		.cpu(cpu),
		.cfg(cfg),
		.psel(psel),
		.penable(penable),
		.pwrite(pwrite),
		.paddr(paddr),
		.pwdata(pwdata),
		.prg_bank(prg_bank),
		.chr_bank(chr_bank),
		.prdata(prdata),
		.pready(pready),
		.pslverr(pslverr)
	);

	prg_map #(
		.PRG_BANK_BITS(PRG_BANK_BITS)
	) u_prg_map (
		.cpu(cpu),
		.prg_bank(prg_bank),
		.prg_do(prg_do),
		.prg(prg),
		.cpu_ret(cpu_ret)
	);

	// top prg bit doubles as the single-screen page on 152
	chr_map #(
		.CHR_BANK_BITS(CHR_BANK_BITS)
	) u_chr_map (
		.ppu(ppu),
		.cfg(cfg),
		.chr_bank(chr_bank),
		.prg_bank_msb(prg_bank[PRG_BANK_BITS-1]),
		.chr_do(chr_do),
		.chr(chr),
		.ppu_ret(ppu_ret),
		.ciram_a10(ciram_a10),
		.ciram_ce(ciram_ce)
	);

endmodule

`default_nettype wire

/* mapper/chr_map.sv */
`timescale 1ns/1ps
`default_nettype none

module chr_map
	import map_bus_pkg::*;
	import map_cfg_pkg::*;
#(
	parameter int CHR_BANK_BITS = 4
)
(
	input wire ppu_bus_t ppu,
	input wire map_cfg_t cfg,
	input wire logic [CHR_BANK_BITS-1:0] chr_bank,
	input wire logic prg_bank_msb,
	input wire logic [7:0] chr_do,
	output mem_ctrl_t chr,
	output ppu_ret_t ppu_ret,
	output logic ciram_a10,
	output logic ciram_ce
);

	localparam int WIN_BITS = 13;	// 8 KiB pattern window

	logic chr_sel;
	logic chr_rd;

	assign chr_sel = ~ppu.addr[13];	// 0x0000-0x1fff

	always_comb
	begin
		chr = '0;
		chr.ce = chr_sel;
		chr.oe = ~ppu.oe_n;
		chr.we = cfg.chr_ram & ~ppu.we_n & chr_sel;	// rom boards never write
		chr.dati = ppu.data;
		chr.addr[WIN_BITS-1:0] = ppu.addr[WIN_BITS-1:0];
		chr.addr[WIN_BITS +: CHR_BANK_BITS] = chr_bank;
	end

	// nametables live in the console's ciram at 0x2000 and up
	assign ciram_ce = ppu.addr[13];

	always_comb
	begin
		if (cfg.map_idx == MAP_152)
			ciram_a10 = prg_bank_msb;	// single screen
		else if (cfg.mir_v)
			ciram_a10 = ppu.addr[10];	// vertical
		else
			ciram_a10 = ppu.addr[11];
	end

	assign chr_rd = chr.ce & chr.oe;

	always_comb
	begin
		ppu_ret.oe = chr_rd;
		ppu_ret.dout = chr_do;
	end

endmodule

`default_nettype wire

/* mapper/prg_map.sv */
`timescale 1ns/1ps
`default_nettype none

module prg_map
	import map_bus_pkg::*;
#(
	parameter int PRG_BANK_BITS = 4
)
(
	input wire cpu_bus_t cpu,
	input wire logic [PRG_BANK_BITS-1:0] prg_bank,
	input wire logic [7:0] prg_do,
	output mem_ctrl_t prg,
	output cpu_ret_t cpu_ret
);

	localparam int WIN_BITS = 14;	// 16 KiB window

	logic [PRG_BANK_BITS-1:0] bank_sel;
	logic prg_rd;

	// 0xc000-0xffff stays on the last bank
	assign bank_sel = cpu.addr[14] ? {PRG_BANK_BITS{1'b1}} : prg_bank;

	always_comb
	begin
		prg = '0;	// unused upper address bits stay low
		prg.ce = cpu.addr[15];
		prg.oe = cpu.rw;
		prg.we = 1'b0;	// rom
		prg.dati = cpu.data;
		prg.addr[WIN_BITS-1:0] = cpu.addr[WIN_BITS-1:0];
		prg.addr[WIN_BITS +: PRG_BANK_BITS] = bank_sel;
	end

	assign prg_rd = prg.ce & prg.oe;

	always_comb
	begin
		cpu_ret.oe = prg_rd;
		cpu_ret.dout = prg_do;
	end

endmodule

`default_nettype wire

/* mapper/bank_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module bank_ctrl
	import map_bus_pkg::*;
	import map_cfg_pkg::*;
#(
	parameter int PRG_BANK_BITS = 4,
	parameter int CHR_BANK_BITS = 4
)
(
	input wire logic m2,
	input wire logic arst_n,
	input wire cpu_bus_t cpu,
	input wire map_cfg_t cfg,
	input wire logic psel,
	input wire logic penable,
	input wire logic pwrite,
	input wire logic [7:0] paddr,
	input wire logic [7:0] pwdata,
	output logic [PRG_BANK_BITS-1:0] prg_bank,
	output logic [CHR_BANK_BITS-1:0] chr_bank,
	output logic [7:0] prdata,
	output logic pready,
	output logic pslverr
);

	// prg field sits in the upper nibble of the written byte
	localparam int PRG_LSB = 4;

	logic [PRG_BANK_BITS-1:0] prg_q;
	logic [CHR_BANK_BITS-1:0] chr_q;
	logic cpu_wr;
	logic apb_access;
	logic sst_wr;
	logic [7:0] bank_byte;
	logic [7:0] sst_rd;

	// any store to 0x8000-0xffff, apb owns the register while selected
	assign cpu_wr = cpu.addr[15] & ~cpu.rw & ~psel;

	assign apb_access = psel & penable;	// second apb cycle
	assign sst_wr = apb_access & pwrite & (paddr == SST_BANK);

	always_ff @(posedge m2 or negedge arst_n)
	begin
		if (!arst_n)
		begin
			prg_q <= '0;
			chr_q <= '0;
		end
		else if (sst_wr)
		begin
			prg_q <= pwdata[PRG_LSB +: PRG_BANK_BITS];	// restore
			chr_q <= pwdata[CHR_BANK_BITS-1:0];
		end
		else if (cpu_wr)
		begin
			prg_q <= cpu.data[PRG_LSB +: PRG_BANK_BITS];
			chr_q <= cpu.data[CHR_BANK_BITS-1:0];
		end
	end

	assign prg_bank = prg_q;
	assign chr_bank = chr_q;

	// register image in the same layout the cpu writes
	always_comb
	begin
		bank_byte = 8'h00;
		bank_byte[PRG_LSB +: PRG_BANK_BITS] = prg_q;
		bank_byte[CHR_BANK_BITS-1:0] = chr_q;
	end

	always_comb
	begin
		case (paddr)
			SST_BANK:
			begin
				sst_rd = bank_byte;
			end
			SST_MAP_IDX:
			begin
				sst_rd = cfg.map_idx;	// loader's index
			end
			default:
			begin
				sst_rd = 8'hff;	// unmapped
			end
		endcase
	end

	// zero wait states, no error response
	assign prdata = apb_access ? sst_rd : 8'h00;
	assign pready = apb_access;
	assign pslverr = 1'b0;

endmodule

`default_nettype wire

/* common/map_cfg_pkg.sv */
`default_nettype none

package map_cfg_pkg;

	// mapper index as seen by the loader
	typedef enum logic [7:0]
	{
		MAP_070 = 8'd70,
		MAP_152 = 8'd152
	} map_id_e;

	// save-state register map
	typedef enum logic [7:0]
	{
		SST_BANK = 8'd0,	// {prg, chr} bank register
		SST_MAP_IDX = 8'd127	// read only
	} sst_reg_e;

	// static cartridge configuration
	typedef struct packed
	{
		map_id_e map_idx;
		logic mir_v;	// vertical mirroring, mapper 70 only
		logic chr_ram;	// chr is writable ram
	} map_cfg_t;

endpackage

`default_nettype wire

/* common/map_bus_pkg.sv */
`default_nettype none

package map_bus_pkg;

	localparam int CPU_AW = 16;	// cpu address space
	localparam int PPU_AW = 14;	// ppu address space
	localparam int MEM_AW = 18;	// widest external memory
	localparam int DW = 8;

	// cpu side, sampled on m2
	typedef struct packed
	{
		logic [CPU_AW-1:0] addr;
		logic [DW-1:0] data;	// write data from the cpu
		logic rw;	// high = read
	} cpu_bus_t;

	// ppu side
	typedef struct packed
	{
		logic [PPU_AW-1:0] addr;
		logic [DW-1:0] data;
		logic oe_n;
		logic we_n;
	} ppu_bus_t;

	// control set for one external memory
	typedef struct packed
	{
		logic ce;
		logic oe;
		logic we;
		logic [MEM_AW-1:0] addr;
		logic [DW-1:0] dati;	// data toward the memory
	} mem_ctrl_t;

	// read data back to the cpu
	typedef struct packed
	{
		logic oe;	// mapper drives the cpu data bus
		logic [DW-1:0] dout;
	} cpu_ret_t;

	// read data back to the ppu
	typedef struct packed
	{
		logic oe;
		logic [DW-1:0] dout;
	} ppu_ret_t;

endpackage

`default_nettype wire
